// ==== logic/xfer_stream_pkg.sv ====
//////////////////////////////
// stream word and result types
//////////////////////////////

package xfer_stream_pkg;

   //////////////////////////////
   // word geometry
   //////////////////////////////

   // number of byte lanes carried by one stream word
   localparam int lane_count = 4;

   // data width of a stream word, one byte per lane
   localparam int word_bits = 32;

   // width of the valid byte count, which holds 1 to lane_count
   localparam int nbytes_bits = 3;

   // one word of the byte stream as it crosses into rdclk
   // byte k of the word sits in lane k and the first byte received is lane 0
   // lanes above nbytes are always zero so the consumer can add them blindly
   typedef struct packed {
      logic [word_bits-1:0]   data;
      logic [nbytes_bits-1:0] nbytes;
      logic                   last;
   } stream_word_t;

   //////////////////////////////
   // frame results
   //////////////////////////////

   // frame byte sum wraps modulo 2**sum_bits
   localparam int sum_bits = 16;

   // frame length in bytes
   localparam int len_bits = 16;

endpackage

// ==== logic/xfer_fifo_pkg.sv ====
//////////////////////////////
// clock crossing FIFO geometry
//////////////////////////////

package xfer_fifo_pkg;

   // storage depth in stream words
   localparam int fifo_depth = 16;

   // address width into the storage array
   // pointers carry one extra wrap bit above this
   localparam int addr_bits = 4;

   // flop stages in each synchronizer
   // the same count serves the Gray pointers and the write side reset
   localparam int sync_stages = 2;

endpackage

// ==== logic/byte_word_packer.sv ====
//////////////////////////////
// byte to word packer
//////////////////////////////

`timescale 1ns/1ps

module byte_word_packer (
   input  logic                         wrclk,
   input  logic                         wr_rst_n,
   input  logic                         byte_valid,
   input  logic [7:0]                   byte_data,
   input  logic                         byte_last,
   output logic                         byte_ready,
   output xfer_stream_pkg::stream_word_t word_out,
   output logic                         word_valid,
   input  logic                         word_ready
);

   // lane that the next accepted byte goes into
   logic [$clog2(xfer_stream_pkg::lane_count)-1:0] lane_cnt;
   // lanes filled so far in the word being built
   logic [xfer_stream_pkg::word_bits-1:0]          acc_data;
   // partial word with the incoming byte placed in its lane
   logic [xfer_stream_pkg::word_bits-1:0]          next_data;
   logic                                           byte_take;
   logic                                           word_close;

   // stall only while a finished word is waiting and the FIFO refuses it
   // a byte is still taken in the cycle the held word leaves
   assign byte_ready = !word_valid || word_ready;
   assign byte_take  = byte_valid && byte_ready;

   // a word closes when its top lane fills or the frame ends
   assign word_close = byte_last ||
                       (32'(lane_cnt) == xfer_stream_pkg::lane_count - 1);

   // lane 0 starts a fresh word so the upper lanes come out zero
   always_comb begin
      next_data = (lane_cnt == '0) ? '0 : acc_data;
      next_data[lane_cnt*8 +: 8] = byte_data;
   end

   //////////////////////////////
   // control state
   //////////////////////////////

   always_ff @(posedge wrclk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         lane_cnt   <= '0;
         word_valid <= 1'b0;
      end else begin
         // held word leaves when the FIFO takes it
         if (word_valid && word_ready) begin
            word_valid <= 1'b0;
         end
         if (byte_take) begin
            if (word_close) begin
               lane_cnt   <= '0;
               word_valid <= 1'b1;
            end else begin
               lane_cnt <= lane_cnt + 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // word payload
   //////////////////////////////

   always_ff @(posedge wrclk) begin
      if (byte_take) begin
         acc_data <= next_data;
         // the output register holds until the FIFO accepts it
         if (word_close) begin
            word_out.data   <= next_data;
            word_out.nbytes <= xfer_stream_pkg::nbytes_bits'(lane_cnt) + 1'b1;
            word_out.last   <= byte_last;
         end
      end
   end

endmodule

// ==== logic/clock_crossing_fifo.sv ====
//////////////////////////////
// dual clock stream FIFO
//////////////////////////////

`timescale 1ns/1ps

module clock_crossing_fifo (
   input  logic                         wrclk,
   input  logic                         rdclk,
   input  logic                         user_mode_sync,
   output logic                         wr_rst_n,
   input  xfer_stream_pkg::stream_word_t wr_data,
   input  logic                         wr_valid,
   output logic                         wr_ready,
   output xfer_stream_pkg::stream_word_t rd_data,
   output logic                         rd_valid,
   input  logic                         rd_ready
);

   // binary to Gray so only one pointer bit moves per step
   function automatic logic [xfer_fifo_pkg::addr_bits:0] bin_to_gray(
      input logic [xfer_fifo_pkg::addr_bits:0] bin
   );
      return bin ^ (bin >> 1);
   endfunction

   // storage shared by both clocks
   xfer_stream_pkg::stream_word_t mem [xfer_fifo_pkg::fifo_depth];

   // reset synchronizer chain for the write side
   logic [xfer_fifo_pkg::sync_stages-1:0] wr_rst_sync;

   // write pointer in both codes and the read pointer seen from wrclk
   logic [xfer_fifo_pkg::addr_bits:0] wr_bin;
   logic [xfer_fifo_pkg::addr_bits:0] wr_gray;
   logic [xfer_fifo_pkg::sync_stages-1:0][xfer_fifo_pkg::addr_bits:0] rd_gray_sync;
   logic [xfer_fifo_pkg::addr_bits:0] rd_gray_wr;

   // read pointer in both codes and the write pointer seen from rdclk
   logic [xfer_fifo_pkg::addr_bits:0] rd_bin;
   logic [xfer_fifo_pkg::addr_bits:0] rd_gray;
   logic [xfer_fifo_pkg::sync_stages-1:0][xfer_fifo_pkg::addr_bits:0] wr_gray_sync;
   logic [xfer_fifo_pkg::addr_bits:0] wr_gray_rd;

   logic wr_full;
   logic rd_empty;
   logic wr_req;
   logic rd_req;

   //////////////////////////////
   // write side reset
   //////////////////////////////

   // asserts with user_mode_sync at once and releases after sync_stages wrclk edges
   always_ff @(posedge wrclk or negedge user_mode_sync) begin
      if (!user_mode_sync) begin
         wr_rst_sync <= '0;
      end else begin
         wr_rst_sync <= {wr_rst_sync[xfer_fifo_pkg::sync_stages-2:0], 1'b1};
      end
   end

   // the packer runs off this same reset
   assign wr_rst_n = wr_rst_sync[xfer_fifo_pkg::sync_stages-1];

   //////////////////////////////
   // write side
   //////////////////////////////

   assign rd_gray_wr = rd_gray_sync[xfer_fifo_pkg::sync_stages-1];

   // full when the pointers differ only in the two top Gray bits
   assign wr_full = (wr_gray == {~rd_gray_wr[xfer_fifo_pkg::addr_bits -: 2],
                                 rd_gray_wr[xfer_fifo_pkg::addr_bits-2:0]});
   assign wr_ready = !wr_full;
   assign wr_req   = wr_valid && wr_ready;

   always_ff @(posedge wrclk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         wr_bin       <= '0;
         wr_gray      <= '0;
         rd_gray_sync <= '0;
      end else begin
         rd_gray_sync <= {rd_gray_sync[xfer_fifo_pkg::sync_stages-2:0], rd_gray};
         if (wr_req) begin
            wr_bin  <= wr_bin + 1'b1;
            wr_gray <= bin_to_gray(wr_bin + 1'b1);
         end
      end
   end

   always_ff @(posedge wrclk) begin
      if (wr_req) begin
         mem[wr_bin[xfer_fifo_pkg::addr_bits-1:0]] <= wr_data;
      end
   end

   //////////////////////////////
   // read side
   //////////////////////////////

   assign wr_gray_rd = wr_gray_sync[xfer_fifo_pkg::sync_stages-1];
   assign rd_empty   = (rd_gray == wr_gray_rd);

   // pop when a word is stored and the output register is free or being read
   assign rd_req = !rd_empty && (!rd_valid || rd_ready);

   always_ff @(posedge rdclk or negedge user_mode_sync) begin
      if (!user_mode_sync) begin
         rd_bin       <= '0;
         rd_gray      <= '0;
         wr_gray_sync <= '0;
         rd_valid     <= 1'b0;
      end else begin
         wr_gray_sync <= {wr_gray_sync[xfer_fifo_pkg::sync_stages-2:0], wr_gray};
         // a read clears the flag and a pop in the same cycle sets it again
         if (rd_ready) begin
            rd_valid <= 1'b0;
         end
         if (rd_req) begin
            rd_valid <= 1'b1;
            rd_bin   <= rd_bin + 1'b1;
            rd_gray  <= bin_to_gray(rd_bin + 1'b1);
         end
      end
   end

   // registered read data lines up with rd_valid
   always_ff @(posedge rdclk) begin
      if (rd_req) begin
         rd_data <= mem[rd_bin[xfer_fifo_pkg::addr_bits-1:0]];
      end
   end

endmodule

// ==== logic/frame_sum_unit.sv ====
//////////////////////////////
// frame sum and length
//////////////////////////////

`timescale 1ns/1ps

module frame_sum_unit (
   input  logic                                  rdclk,
   input  logic                                  user_mode_sync,
   input  xfer_stream_pkg::stream_word_t          word_in,
   input  logic                                  word_valid,
   output logic                                  word_ready,
   input  logic                                  drain_enable,
   output logic                                  frame_done,
   output logic [xfer_stream_pkg::sum_bits-1:0]  frame_sum,
   output logic [xfer_stream_pkg::len_bits-1:0]  frame_len
);

   // running totals of the frame in progress
   logic [xfer_stream_pkg::sum_bits-1:0] acc_sum;
   logic [xfer_stream_pkg::len_bits-1:0] acc_len;
   // byte sum of the word on the input
   logic [xfer_stream_pkg::sum_bits-1:0] word_sum;
   logic                                 word_take;

   // draining is a plain level from outside
   assign word_ready = drain_enable;
   assign word_take  = word_valid && word_ready;

   // unused lanes arrive as zero so every lane can be added
   always_comb begin
      word_sum = '0;
      for (int k = 0; k < xfer_stream_pkg::lane_count; k++) begin
         word_sum = word_sum + xfer_stream_pkg::sum_bits'(word_in.data[k*8 +: 8]);
      end
   end

   always_ff @(posedge rdclk or negedge user_mode_sync) begin
      if (!user_mode_sync) begin
         acc_sum    <= '0;
         acc_len    <= '0;
         frame_done <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         if (word_take) begin
            if (word_in.last) begin
               // the next frame starts from zero
               acc_sum    <= '0;
               acc_len    <= '0;
               frame_done <= 1'b1;
            end else begin
               acc_sum <= acc_sum + word_sum;
               acc_len <= acc_len + xfer_stream_pkg::len_bits'(word_in.nbytes);
            end
         end
      end
   end

   // results hold from one frame_done to the next
   always_ff @(posedge rdclk) begin
      if (word_take && word_in.last) begin
         frame_sum <= acc_sum + word_sum;
         frame_len <= acc_len + xfer_stream_pkg::len_bits'(word_in.nbytes);
      end
   end

endmodule

// ==== logic/xfer_top.sv ====
//////////////////////////////
// byte stream transfer top
//////////////////////////////

`timescale 1ns/1ps

module xfer_top (
   input  logic                                 wrclk,
   input  logic                                 rdclk,
   input  logic                                 user_mode_sync,
   input  logic                                 byte_valid,
   input  logic [7:0]                           byte_data,
   input  logic                                 byte_last,
   output logic                                 byte_ready,
   input  logic                                 drain_enable,
   output logic                                 frame_done,
   output logic [xfer_stream_pkg::sum_bits-1:0] frame_sum,
   output logic [xfer_stream_pkg::len_bits-1:0] frame_len
);

   // write side reset made inside the FIFO
   logic                          wr_rst_n;
   // packer to FIFO in wrclk
   xfer_stream_pkg::stream_word_t packed_word;
   logic                          packed_valid;
   logic                          packed_ready;
   // FIFO to consumer in rdclk
   xfer_stream_pkg::stream_word_t fifo_word;
   logic                          fifo_valid;
   logic                          fifo_ready;

   byte_word_packer byte_word_packer_inst (
      .wrclk      (wrclk),
      .wr_rst_n   (wr_rst_n),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .byte_last  (byte_last),
      .byte_ready (byte_ready),
      .word_out   (packed_word),
      .word_valid (packed_valid),
      .word_ready (packed_ready)
   );

   clock_crossing_fifo clock_crossing_fifo_inst (
      .wrclk          (wrclk),
      .rdclk          (rdclk),
      .user_mode_sync (user_mode_sync),
      .wr_rst_n       (wr_rst_n),
      .wr_data        (packed_word),
      .wr_valid       (packed_valid),
      .wr_ready       (packed_ready),
      .rd_data        (fifo_word),
      .rd_valid       (fifo_valid),
      .rd_ready       (fifo_ready)
   );

   frame_sum_unit frame_sum_unit_inst (
      .rdclk          (rdclk),
      .user_mode_sync (user_mode_sync),
      .word_in        (fifo_word),
      .word_valid     (fifo_valid),
      .word_ready     (fifo_ready),
      .drain_enable   (drain_enable),
      .frame_done     (frame_done),
      .frame_sum      (frame_sum),
      .frame_len      (frame_len)
   );

endmodule

// ==== sim/xfer_top_tb.sv ====
//////////////////////////////
// byte stream transfer testbench
//////////////////////////////

`timescale 1ns/1ps

module xfer_top_tb;

   // wrclk runs unrelated to rdclk so the pointer crossings see every phase
   localparam int wr_period_ns = 70;
   localparam int rd_period_ns = 100;
   // worst case byte count over all tests with every random frame at its longest
   localparam longint max_bytes = 3 + 45 + 80 + 30 * 40;
   localparam longint timeout_ns = max_bytes * wr_period_ns * 4 + 20000;
   // FIFO words plus the read register and the held packer word
   localparam int stall_bound = xfer_fifo_pkg::fifo_depth * 4 + 8;

   logic                                 wrclk = 1'b0;
   logic                                 rdclk = 1'b0;
   logic                                 user_mode_sync;
   logic                                 byte_valid;
   logic [7:0]                           byte_data;
   logic                                 byte_last;
   logic                                 byte_ready;
   logic                                 drain_enable;
   logic                                 frame_done;
   logic [xfer_stream_pkg::sum_bits-1:0] frame_sum;
   logic [xfer_stream_pkg::len_bits-1:0] frame_len;

   int     errors = 0;
   integer seed = 32'h393b;
   string  cur_test = "reset";
   // expected results in frame order are pushed before the first byte goes out
   logic [xfer_stream_pkg::sum_bits-1:0] exp_sum_q[$];
   logic [xfer_stream_pkg::len_bits-1:0] exp_len_q[$];
   // back-pressure bookkeeping that the stall test clears before it starts
   int accepted_bytes = 0;
   bit stall_seen = 1'b0;
   int bytes_at_stall = 0;
   bit frame_sent = 1'b0;
   bit sending = 1'b0;

   always #(wr_period_ns / 2) wrclk = ~wrclk;
   always #(rd_period_ns / 2) rdclk = ~rdclk;

   xfer_top xfer_top_inst (
      .wrclk          (wrclk),
      .rdclk          (rdclk),
      .user_mode_sync (user_mode_sync),
      .byte_valid     (byte_valid),
      .byte_data      (byte_data),
      .byte_last      (byte_last),
      .byte_ready     (byte_ready),
      .drain_enable   (drain_enable),
      .frame_done     (frame_done),
      .frame_sum      (frame_sum),
      .frame_len      (frame_len)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("error %s expected 0x%0h actual 0x%0h", name, expected, actual);
      end
   endtask

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   // called 5 ns after a wrclk edge where byte_ready has settled for the next edge
   task automatic send_byte(input logic [7:0] data, input logic last);
      logic taken;
      byte_valid = 1'b1;
      byte_data  = data;
      byte_last  = last;
      taken      = 1'b0;
      while (!taken) begin
         taken = byte_ready;
         // remember how far the stream got before the first stall
         if (!taken && !stall_seen) begin
            stall_seen     = 1'b1;
            bytes_at_stall = accepted_bytes;
         end
         @(posedge wrclk);
         #5;
      end
      accepted_bytes++;
      byte_valid = 1'b0;
      byte_last  = 1'b0;
   endtask

   // reference model is the plain byte sum modulo 2**16 and the byte count
   task automatic send_frame(input int len, input bit gaps);
      logic [7:0]                           data_q[$];
      logic [xfer_stream_pkg::sum_bits-1:0] sum;
      logic [31:0]                          rnd;
      sum = '0;
      for (int i = 0; i < len; i++) begin
         rnd = $random(seed);
         data_q.push_back(rnd[7:0]);
         sum = sum + xfer_stream_pkg::sum_bits'(rnd[7:0]);
      end
      exp_sum_q.push_back(sum);
      exp_len_q.push_back(xfer_stream_pkg::len_bits'(len));
      @(posedge wrclk);
      #5;
      for (int i = 0; i < len; i++) begin
         send_byte(data_q[i], i == len - 1);
         rnd = $random(seed);
         // an occasional idle cycle inside the frame
         if (gaps && rnd[1:0] == 2'b00) begin
            @(posedge wrclk);
            #5;
         end
      end
   endtask

   task automatic set_drain(input logic value);
      @(posedge rdclk);
      #5;
      drain_enable = value;
   endtask

   // bounded wait for every outstanding result to come back
   task automatic wait_results();
      int n;
      n = 0;
      while (exp_sum_q.size() != 0 && n < 4000) begin
         @(posedge rdclk);
         n++;
      end
      if (exp_sum_q.size() != 0) begin
         errors++;
         $display("%s gave up waiting for %0d frame results", cur_test, exp_sum_q.size());
      end
   endtask

   //////////////////////////////
   // result monitor
   //////////////////////////////

   // frame_done lasts one rdclk cycle so the falling edge sees each pulse once
   always @(negedge rdclk) begin
      if (frame_done === 1'b1) begin
         if (exp_sum_q.size() == 0) begin
            errors++;
            $display("%s saw frame_done with no frame outstanding", cur_test);
         end else begin
            check_value({cur_test, " sum"}, 32'(exp_sum_q.pop_front()), 32'(frame_sum));
            check_value({cur_test, " len"}, 32'(exp_len_q.pop_front()), 32'(frame_len));
         end
      end
   end

   //////////////////////////////
   // directed tests
   //////////////////////////////

   task automatic test_reset_idle();
      cur_test = "test_reset_idle";
      repeat (20) begin
         @(negedge rdclk);
         check_value(cur_test, 32'd0, 32'(frame_done));
      end
      check_value(cur_test, 32'd1, 32'(byte_ready));
   endtask

   task automatic test_short_frame();
      cur_test = "test_short_frame";
      send_frame(3, 1'b0);
      wait_results();
   endtask

   task automatic test_length_sweep();
      cur_test = "test_length_sweep";
      for (int len = 1; len <= 9; len++) begin
         send_frame(len, 1'b0);
      end
      wait_results();
   endtask

   task automatic test_backpressure();
      cur_test = "test_backpressure";
      set_drain(1'b0);
      stall_seen     = 1'b0;
      accepted_bytes = 0;
      frame_sent     = 1'b0;
      fork
         begin
            send_frame(80, 1'b0);
            frame_sent = 1'b1;
         end
         begin
            wait (stall_seen || frame_sent);
            if (!stall_seen) begin
               errors++;
               $display("byte_ready never dropped while the FIFO was blocked");
            end else if (bytes_at_stall > stall_bound) begin
               errors++;
               $display("byte_ready dropped only after %0d bytes were taken", bytes_at_stall);
            end
            set_drain(1'b1);
         end
      join
      wait_results();
   endtask

   task automatic test_random_frames();
      logic [31:0] rnd_f;
      logic [31:0] rnd_d;
      cur_test = "test_random_frames";
      sending  = 1'b1;
      fork
         begin
            for (int f = 0; f < 30; f++) begin
               rnd_f = $random(seed);
               send_frame(1 + int'(rnd_f[15:0]) % 40, 1'b1);
               repeat (rnd_f[18:16]) @(posedge wrclk);
            end
            sending = 1'b0;
         end
         begin
            // drain toggles at random until the last frame is in
            while (sending) begin
               rnd_d = $random(seed);
               set_drain(rnd_d[0]);
               repeat (rnd_d[3:1]) @(posedge rdclk);
            end
            set_drain(1'b1);
         end
      join
      wait_results();
   endtask

   //////////////////////////////
   // run control
   //////////////////////////////

   initial begin
      user_mode_sync = 1'b0;
      byte_valid     = 1'b0;
      byte_data      = 8'h00;
      byte_last      = 1'b0;
      drain_enable   = 1'b1;
      repeat (5) @(posedge rdclk);
      #5;
      user_mode_sync = 1'b1;
      test_reset_idle();
      test_short_frame();
      test_length_sweep();
      test_backpressure();
      test_random_frames();
      repeat (10) @(posedge rdclk);
      if (exp_sum_q.size() != 0) begin
         errors++;
         $display("%0d expected frame results never arrived", exp_sum_q.size());
      end
      $display("errors %0d", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // watchdog sized from the longest possible byte traffic
   initial begin
      #(timeout_ns);
      $display("timeout in %s after %0d ns", cur_test, timeout_ns);
      $display("errors %0d", errors + 1);
      $display("tests failed");
      $finish;
   end

endmodule

// ==== files.f ====
logic/xfer_stream_pkg.sv
logic/xfer_fifo_pkg.sv
logic/byte_word_packer.sv
logic/clock_crossing_fifo.sv
logic/frame_sum_unit.sv
logic/xfer_top.sv
sim/xfer_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the xfer_top testbench with Verilator
# the log is searched for the pass line to decide the result

cd "$(dirname "$0")" || exit 1

rm -f sim.log \
   && verilator --binary --timing --top-module xfer_top_tb -f files.f -o xfer_sim \
   && ./obj_dir/xfer_sim | tee sim.log \
   && grep -q "all tests passed" sim.log \
   && echo "run_sim: PASS" \
   || { echo "run_sim: FAIL, see sim.log"; exit 1; }
